// ==== uart_pkg.sv ====
package uart_pkg;

  // serial line timing.
  localparam int CYCLES_PER_BIT  = 4;  // clocks per serial bit.
  localparam int EXTRA_STOP_BITS = 7;  // guard bits after a frame before idle.
  localparam int FRAME_BITS      = 10; // start, 8 data, stop.

  // transmit queue size.
  localparam int FIFO_DEPTH = 8;

  // bit timer, shared by transmitter and receiver.
  localparam int                  CYCLE_W   = $clog2(CYCLES_PER_BIT);
  localparam logic [CYCLE_W-1:0]  CYCLE_MAX = CYCLE_W'(CYCLES_PER_BIT - 1);
  localparam logic [CYCLE_W-1:0]  HALF_MAX  = CYCLE_W'(CYCLES_PER_BIT / 2 - 1); // to mid-bit.

  // transmit cursor counts down over frame plus guard bits.
  localparam int                   CURSOR_W     = $clog2(FRAME_BITS + EXTRA_STOP_BITS);
  localparam logic [CURSOR_W-1:0]  CURSOR_MAX   = CURSOR_W'(FRAME_BITS + EXTRA_STOP_BITS - 1);
  localparam logic [CURSOR_W-1:0]  GUARD_CURSOR = CURSOR_W'(EXTRA_STOP_BITS); // stop bit slot.

  // queue pointers and fill level.
  localparam int                PTR_W     = $clog2(FIFO_DEPTH);
  localparam int                CNT_W     = $clog2(FIFO_DEPTH + 1);
  localparam logic [PTR_W-1:0]  PTR_LAST  = PTR_W'(FIFO_DEPTH - 1);
  localparam logic [CNT_W-1:0]  FIFO_FULL = CNT_W'(FIFO_DEPTH);

  // strobe-qualified byte, host side and queue head.
  typedef struct packed {
    logic       valid; // one-cycle strobe, or queue not empty at the head.
    logic [7:0] data;
  } tx_byte_t;

  // receiver result, valid for one cycle.
  typedef struct packed {
    logic       valid;
    logic       frame_err; // stop bit was sampled low.
    logic [7:0] data;
  } rx_byte_t;

endpackage

// ==== uart_tx_fifo.sv ====
`timescale 1ns/10ps

module uart_tx_fifo (
  input  logic               clk,
  input  logic               rst_n,
  input  uart_pkg::tx_byte_t i_wr,       // host write strobe and byte.
  input  logic               i_ack,      // transmitter took the head.
  output uart_pkg::tx_byte_t o_head,     // oldest entry, valid when not empty.
  output logic               o_overflow  // sticky, a write hit a full queue.
);

  logic [7:0]                 mem [uart_pkg::FIFO_DEPTH]; // byte storage.
  logic [uart_pkg::PTR_W-1:0] rd_ptr;
  logic [uart_pkg::PTR_W-1:0] wr_ptr;
  logic [uart_pkg::CNT_W-1:0] count;  // entries held.
  logic                       full;
  logic                       push;
  logic                       pop;

  // step a pointer round the ring.
  function automatic logic [uart_pkg::PTR_W-1:0] next_ptr(
    input logic [uart_pkg::PTR_W-1:0] ptr
  );
    if (ptr == uart_pkg::PTR_LAST) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full = (count == uart_pkg::FIFO_FULL);
  assign pop  = i_ack;                           // only the transmitter pops.
  assign push = i_wr.valid && (!full || pop);    // a pop frees a slot this cycle.

  // storage, no reset needed.
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= i_wr.data;
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr     <= '0;
      wr_ptr     <= '0;
      count      <= '0;
      o_overflow <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // both or neither.
      endcase
      // dropped write latches until reset.
      if (i_wr.valid && !push) begin
        o_overflow <= 1'b1;
      end
    end
  end

  // head is visible the cycle after the write.
  always_comb begin
    o_head.valid = (count != '0);
    o_head.data  = mem[rd_ptr];
  end

  // transmitter must only accept a real head.
  a_ack_needs_head: assert property (
    @(posedge clk) disable iff (!rst_n) i_ack |-> o_head.valid
  ) else $error("uart_tx_fifo: ack while queue empty");

  // fill level stays in range across push and pop.
  a_count_range: assert property (
    @(posedge clk) disable iff (!rst_n) count <= uart_pkg::FIFO_FULL
  ) else $error("uart_tx_fifo: count above depth");

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/10ps

module uart_tx (
  input  logic               clk,
  input  logic               rst_n,
  input  uart_pkg::tx_byte_t i_head,   // queue head, valid when not empty.
  output logic               o_ack,    // one-cycle accept strobe.
  output logic               o_serial, // line out, high when idle.
  output logic               o_idle    // guard period over, nothing in flight.
);

  logic [uart_pkg::CYCLE_W-1:0]  cycle;  // cycles left in current bit.
  logic [uart_pkg::CURSOR_W-1:0] cursor; // bits left, frame then guard.
  logic [8:0]                    buffer; // start bit plus data, ones fill in.
  logic                          ready;

  // cursor map: max is the start bit, guard value is the stop bit,
  // below that are the extra stop bits.
  assign ready    = (cursor <= uart_pkg::GUARD_CURSOR) && (cycle == '0); // last stop cycle on.
  assign o_ack    = i_head.valid && ready;
  assign o_serial = buffer[0];                                    // lsb goes out first.

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      cycle  <= '0;
      cursor <= '0;
      buffer <= 9'h1ff; // line high.
    end else if (o_ack) begin
      // load frame, start bit leads.
      cycle  <= uart_pkg::CYCLE_MAX;
      cursor <= uart_pkg::CURSOR_MAX;
      buffer <= {i_head.data, 1'b0};
    end else if (cycle != '0) begin
      cycle <= cycle - 1'b1; // hold current bit.
    end else if (cursor != '0) begin
      // next bit, a one shifts in at the top.
      cycle  <= uart_pkg::CYCLE_MAX;
      cursor <= cursor - 1'b1;
      buffer <= {1'b1, buffer[8:1]};
    end
  end

  // idle comes up in the cycle after the last guard bit ends.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      o_idle <= 1'b1;
    end else begin
      o_idle <= (cursor == '0) && (cycle == '0) && !o_ack; // a new frame keeps it low.
    end
  end

  // accept only when ready, start bit is on the line the next cycle.
  a_ack_start: assert property (
    @(posedge clk) disable iff (!rst_n)
    o_ack |-> ready ##1 (!o_serial && (cursor == uart_pkg::CURSOR_MAX))
  ) else $error("uart_tx: ack without a following start bit");

  // line stays high through the extra stop bits.
  a_guard_high: assert property (
    @(posedge clk) disable iff (!rst_n)
    (cursor < uart_pkg::GUARD_CURSOR) |-> o_serial
  ) else $error("uart_tx: line low in guard period");

endmodule

// ==== uart_rx.sv ====
`timescale 1ns/10ps

module uart_rx (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               i_serial, // async line in.
  input  logic               i_clear,  // zero the running sum.
  output uart_pkg::rx_byte_t o_rx,     // result strobe at stop mid-bit.
  output logic [7:0]         o_sum     // modulo-256 sum of good bytes.
);

  typedef enum logic [2:0] {
    HUNT,      // wait for a falling edge.
    START,     // half-bit delay, confirm start.
    DATA,      // sample eight bits.
    STOP,      // sample stop bit.
    WAIT_HIGH  // after a framing error, wait for idle line.
  } rx_state_t;

  rx_state_t                    state;
  logic [1:0]                   sync;     // two-flop synchroniser.
  logic                         line;     // synchronised line.
  logic                         line_q;   // previous line, for edge detect.
  logic [uart_pkg::CYCLE_W-1:0] cycle;    // cycles to next sample point.
  logic [2:0]                   bit_idx;  // data bit being sampled.
  logic [7:0]                   shift;    // data, lsb arrives first.
  logic                         sample;
  logic                         good_byte;
  logic                         valid_q;
  logic                         err_q;

  assign line      = sync[1];
  assign sample    = (cycle == '0);
  assign good_byte = (state == STOP) && sample && line; // stop bit high.

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      sync    <= 2'b11; // idle line.
      line_q  <= 1'b1;
      state   <= HUNT;
      cycle   <= '0;
      bit_idx <= '0;
      valid_q <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      sync    <= {sync[0], i_serial};
      line_q  <= line;
      valid_q <= 1'b0; // strobe lasts one cycle.
      if (cycle != '0) begin
        cycle <= cycle - 1'b1;
      end
      case (state)
        HUNT: begin
          if (line_q && !line) begin
            cycle <= uart_pkg::HALF_MAX; // go to start bit centre.
            state <= START;
          end
        end
        START: begin
          if (sample) begin
            if (!line) begin
              cycle   <= uart_pkg::CYCLE_MAX;
              bit_idx <= '0;
              state   <= DATA;
            end else begin
              state <= HUNT; // glitch, not a start bit.
            end
          end
        end
        DATA: begin
          if (sample) begin
            cycle   <= uart_pkg::CYCLE_MAX;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= STOP;
            end
          end
        end
        STOP: begin
          if (sample) begin
            valid_q <= 1'b1;
            err_q   <= !line;
            state   <= line ? HUNT : WAIT_HIGH;
          end
        end
        WAIT_HIGH: begin
          if (line) begin
            state <= HUNT; // break over.
          end
        end
        default: state <= HUNT;
      endcase
    end
  end

  // data shifter, no reset needed.
  always_ff @(posedge clk) begin
    if ((state == DATA) && sample) begin
      shift <= {line, shift[7:1]};
    end
  end

  // running sum, clear wins but keeps a byte landing in the same cycle.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      o_sum <= '0;
    end else if (i_clear) begin
      o_sum <= good_byte ? shift : 8'h00;
    end else if (good_byte) begin
      o_sum <= o_sum + shift; // wraps modulo 256.
    end
  end

  // shift holds the whole byte until the next frame's first data bit.
  always_comb begin
    o_rx.valid     = valid_q;
    o_rx.frame_err = err_q;
    o_rx.data      = shift;
  end

  // a frame is far longer than one cycle, strobes never touch.
  a_single_strobe: assert property (
    @(posedge clk) disable iff (!rst_n) o_rx.valid |=> !o_rx.valid
  ) else $error("uart_rx: result strobe held two cycles");

endmodule

// ==== uart_top.sv ====
`timescale 1ns/10ps

module uart_top (
  input  logic               clk,
  input  logic               rst_n,
  input  uart_pkg::tx_byte_t i_wr,       // host byte strobe.
  input  logic               i_serial,   // receive line.
  input  logic               i_clear,    // clear receive sum.
  output logic               o_serial,   // transmit line.
  output logic               o_idle,     // transmitter done with guard.
  output logic               o_overflow, // sticky queue overflow.
  output uart_pkg::rx_byte_t o_rx,       // received byte strobe.
  output logic [7:0]         o_sum       // sum of good received bytes.
);

  uart_pkg::tx_byte_t head; // queue head to transmitter.
  logic               ack;  // transmitter pop strobe.

  // host bytes wait here.
  uart_tx_fifo i_uart_tx_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_wr       (i_wr),
    .i_ack      (ack),
    .o_head     (head),
    .o_overflow (o_overflow)
  );

  // framing and guard period.
  uart_tx i_uart_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_head   (head),
    .o_ack    (ack),
    .o_serial (o_serial),
    .o_idle   (o_idle)
  );

  // independent receive path.
  uart_rx i_uart_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_serial (i_serial),
    .i_clear  (i_clear),
    .o_rx     (o_rx),
    .o_sum    (o_sum)
  );

endmodule

// ==== tb_uart_top.sv ====
`timescale 1ns/10ps

module tb_uart_top;

  logic               clk = 1'b0;
  logic               rst_n;
  uart_pkg::tx_byte_t i_wr;
  logic               i_serial = 1'b1; // loopback line, idle high.
  logic               i_clear;
  logic               o_serial;
  logic               o_idle;
  logic               o_overflow;
  uart_pkg::rx_byte_t o_rx;
  logic [7:0]         o_sum;

  int         seed = 32'h972f;
  int         errors = 0;          // mismatches seen by the main sequence.
  int         monitor_errors = 0;  // mismatches seen on the line and at the receiver.
  int         timeouts = 0;
  logic       brk;                 // holds the receive line low.
  logic [8:0] expect_q[$];         // {frame_err, data}, oldest first.
  logic [7:0] model_sum = 8'h00;   // modulo-256 sum of good bytes.
  int         cyc = 0;             // monitor cycle count.
  int         last_fall = 0;       // cycle of the latest start bit.
  logic       fall_seen = 1'b0;    // a frame went out since the last idle.
  logic       serial_q = 1'b1;
  logic       idle_q = 1'b1;

  always #5 clk = ~clk; // 10 ns period.

  // loopback register, break overrides it.
  always @(posedge clk) begin
    i_serial <= brk ? 1'b0 : o_serial;
  end

  uart_top i_uart_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_wr       (i_wr),
    .i_serial   (i_serial),
    .i_clear    (i_clear),
    .o_serial   (o_serial),
    .o_idle     (o_idle),
    .o_overflow (o_overflow),
    .o_rx       (o_rx),
    .o_sum      (o_sum)
  );

  function automatic int frame_cycles();
    return uart_pkg::FRAME_BITS * uart_pkg::CYCLES_PER_BIT; // start to start.
  endfunction

  // one frame plus the guard bits after its stop bit.
  function automatic int idle_delay_cycles();
    return (uart_pkg::FRAME_BITS + uart_pkg::EXTRA_STOP_BITS) * uart_pkg::CYCLES_PER_BIT;
  endfunction

  // compare one receiver strobe with the oldest byte sent.
  task automatic check_rx_byte();
    logic [8:0] want;
    if (expect_q.size() == 0) begin
      $display("ERROR: receiver gave byte %02h at %0t ns with nothing outstanding",
               o_rx.data, $time);
      monitor_errors++;
    end else begin
      want = expect_q.pop_front();
      if (o_rx.frame_err != want[8] || o_rx.data != want[7:0]) begin
        $display("FAILED %0t ns: rx err=%0b data=%02h, expected err=%0b data=%02h",
                 $time, o_rx.frame_err, o_rx.data, want[8], want[7:0]);
        monitor_errors++;
      end
      if (!want[8]) begin
        model_sum = model_sum + want[7:0]; // bad frames leave the sum alone.
      end
      if (o_sum != model_sum) begin
        $display("FAILED %0t ns: o_sum %02h, expected %02h", $time, o_sum, model_sum);
        monitor_errors++;
      end
    end
  endtask

  // line and receiver monitor, sampled mid-cycle.
  always @(negedge clk) begin
    cyc = cyc + 1;
    if (rst_n) begin
      if (i_clear) begin
        model_sum = 8'h00;
      end
      // a fall within a frame of the last start is a data bit.
      if (serial_q && !o_serial) begin
        if (!fall_seen) begin
          fall_seen = 1'b1;
          last_fall = cyc;
        end else if (cyc - last_fall >= frame_cycles()) begin
          if (cyc - last_fall != frame_cycles()) begin
            $display("FAILED %0t ns: start bits %0d cycles apart, expected %0d",
                     $time, cyc - last_fall, frame_cycles());
            monitor_errors++;
          end
          last_fall = cyc;
        end
      end
      if (!idle_q && o_idle) begin
        if (!fall_seen) begin
          $display("ERROR: o_idle rose at %0t ns with no frame on the line", $time);
          monitor_errors++;
        end else if (cyc - last_fall != idle_delay_cycles()) begin
          $display("FAILED %0t ns: o_idle rose %0d cycles after start bit, expected %0d",
                   $time, cyc - last_fall, idle_delay_cycles());
          monitor_errors++;
        end
        fall_seen = 1'b0; // next start begins a new burst.
      end
      if (o_rx.valid) begin
        check_rx_byte();
      end
    end
    serial_q = o_serial;
    idle_q   = o_idle;
  end

  // random bytes, gaps of 0 to max_gap cycles, the first keep of them expected back.
  task automatic write_burst(input int count, input int max_gap, input int keep);
    int         gap;
    logic [7:0] d;
    for (int i = 0; i < count; i++) begin
      d = 8'($random(seed));
      @(posedge clk);
      i_wr.valid <= 1'b1;
      i_wr.data  <= d;
      if (i < keep) begin
        expect_q.push_back({1'b0, d});
      end
      gap = int'($unsigned($random(seed)) % (max_gap + 1));
      repeat (gap) begin
        @(posedge clk);
        i_wr.valid <= 1'b0;
      end
    end
    @(posedge clk);
    i_wr.valid <= 1'b0;
  endtask

  task automatic wait_rx_drained(input int limit);
    int n;
    n = 0;
    while (expect_q.size() != 0 && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (expect_q.size() != 0) begin
      $display("ERROR: timed out at %0t ns with %0d bytes not received",
               $time, expect_q.size());
      timeouts++;
    end
  endtask

  task automatic wait_idle(input int limit);
    int n;
    n = 0;
    while (!o_idle && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (!o_idle) begin
      $display("ERROR: transmitter did not go idle by %0t ns", $time);
      timeouts++;
    end
  endtask

  initial begin
    int         n;
    logic [7:0] sum_before;
    rst_n   = 1'b0;
    i_wr    = '0;
    i_clear = 1'b0;
    brk     = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (o_serial !== 1'b1 || o_idle !== 1'b1 || o_overflow !== 1'b0 ||
        o_rx.valid !== 1'b0 || o_sum !== 8'h00) begin
      $display("FAILED %0t ns: reset state serial=%b idle=%b ovf=%b valid=%b sum=%02h",
               $time, o_serial, o_idle, o_overflow, o_rx.valid, o_sum);
      errors++;
    end

    // random bursts, short enough that the queue never runs dry mid-burst.
    for (int b = 0; b < 20; b++) begin
      n = 1 + int'($unsigned($random(seed)) % uart_pkg::FIFO_DEPTH);
      repeat (int'($unsigned($random(seed)) % 8)) @(posedge clk);
      write_burst(n, 3, n);
      wait_rx_drained((uart_pkg::FIFO_DEPTH + 2) * frame_cycles());
      wait_idle(2 * idle_delay_cycles());
      if (o_sum !== model_sum) begin
        $display("FAILED %0t ns: burst %0d sum %02h, expected %02h", $time, b, o_sum, model_sum);
        errors++;
      end
      if (o_overflow !== 1'b0) begin
        $display("FAILED %0t ns: overflow set during burst %0d", $time, b);
        errors++;
      end
    end

    // back-to-back writes, one pop fits in the burst, the rest fill the queue.
    write_burst(2 * uart_pkg::FIFO_DEPTH, 0, uart_pkg::FIFO_DEPTH + 1);
    @(negedge clk);
    if (o_overflow !== 1'b1) begin
      $display("FAILED %0t ns: o_overflow not set after a full queue", $time);
      errors++;
    end
    wait_rx_drained((uart_pkg::FIFO_DEPTH + 2) * frame_cycles());
    wait_idle(2 * idle_delay_cycles());

    // break, twelve bit times low.
    sum_before = model_sum;
    expect_q.push_back({1'b1, 8'h00});
    @(posedge clk);
    brk <= 1'b1;
    repeat (12 * uart_pkg::CYCLES_PER_BIT) @(posedge clk);
    brk <= 1'b0;
    wait_rx_drained(2 * frame_cycles());
    if (o_sum !== sum_before) begin
      $display("FAILED %0t ns: sum moved to %02h on a break", $time, o_sum);
      errors++;
    end
    repeat (2 * uart_pkg::CYCLES_PER_BIT) @(posedge clk); // line settles high.
    write_burst(1, 0, 1);
    wait_rx_drained(2 * frame_cycles());
    wait_idle(2 * idle_delay_cycles());

    // sum clear, then a fresh burst.
    @(posedge clk);
    i_clear <= 1'b1;
    @(posedge clk);
    i_clear <= 1'b0;
    @(negedge clk);
    if (o_sum !== 8'h00) begin
      $display("FAILED %0t ns: sum %02h after clear", $time, o_sum);
      errors++;
    end
    n = 1 + int'($unsigned($random(seed)) % uart_pkg::FIFO_DEPTH);
    write_burst(n, 3, n);
    wait_rx_drained((uart_pkg::FIFO_DEPTH + 2) * frame_cycles());
    wait_idle(2 * idle_delay_cycles());
    if (o_sum !== model_sum) begin
      $display("FAILED %0t ns: sum %02h after clear and burst, expected %02h",
               $time, o_sum, model_sum);
      errors++;
    end

    $display("summary: %0d check errors, %0d monitor errors, %0d timeouts",
             errors, monitor_errors, timeouts);
    if (errors == 0 && monitor_errors == 0 && timeouts == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== build.f ====
uart_pkg.sv
uart_tx_fifo.sv
uart_tx.sv
uart_rx.sv
uart_top.sv
tb_uart_top.sv

// ==== Makefile ====
# Verilator build and run of the UART link testbench.

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove the build folder and $(LOG)"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module tb_uart_top -f build.f --Mdir obj_dir -o tb_uart_top
	./obj_dir/tb_uart_top > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF "*** TEST PASSED ***" $(LOG); then \
		echo "result: pass"; \
	else \
		echo "result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
